// File: source/profiler_pkg.sv
package profiler_pkg;

  localparam int NUM_REASONS = 12;
  localparam int REASON_W    = 4;
  localparam int COUNT_W     = 32;
  localparam int ADDR_W      = 8;

  // Byte addresses, one 32-bit word per register
  localparam logic [ADDR_W-1:0] CTRL_ADDR     = 8'h00;
  localparam logic [ADDR_W-1:0] CNT_BASE_ADDR = 8'h04;
  localparam logic [ADDR_W-1:0] RETIRE_ADDR   = 8'h34;

  // Lower code wins when several reasons are present
  typedef enum logic [REASON_W-1:0] {
    unknown   = 4'd0,
    cmt_haz   = 4'd1,
    exception = 4'd2,
    fence     = 4'd3,
    br_miss   = 4'd4,
    fu_busy   = 4'd5,
    br_haz    = 4'd6,
    raw_haz   = 4'd7,
    sb_full   = 4'd8,
    bp_haz    = 4'd9,
    ic_miss   = 4'd10,
    iq_full   = 4'd11
  } stall_code_e;

  // Field position matches the code value
  typedef struct packed {
    logic iq_full;
    logic ic_miss;
    logic bp_haz;
    logic sb_full;
    logic raw_haz;
    logic br_haz;
    logic fu_busy;
    logic br_miss;
    logic fence;
    logic exception;
    logic cmt_haz;
    logic unknown;
  } stall_flags_s;

  typedef union packed {
    stall_flags_s           flags;
    logic [NUM_REASONS-1:0] bits;
  } stall_word_u;

  typedef struct packed {
    logic iq_ready;
    logic ic_miss;
    logic bp_bubble;
    logic iq_valid;
  } fetch_status_s;

  typedef struct packed {
    logic is_valid;
    logic is_ack;
    logic sb_full;
    logic unresolved_branch;
    logic ro_stall;
    logic fu_busy;
  } issue_status_s;

  typedef struct packed {
    logic branch_mispredict;
    logic exception;
    logic flush_unissued;
  } flush_status_s;

  // Second port only feeds the retire count
  typedef struct packed {
    logic cmt_valid;
    logic cmt_ack;
    logic cmt_ack1;
  } commit_status_s;

  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [ADDR_W-1:0]  paddr;
    logic [COUNT_W-1:0] pwdata;
  } apb_req_s;

  typedef struct packed {
    logic [COUNT_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
  } apb_rsp_s;

endpackage

// File: source/frontend_stall_stage.sv
module frontend_stall_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  profiler_pkg::fetch_status_s fetch_i,
  input  profiler_pkg::flush_status_s flush_i,
  output profiler_pkg::stall_word_u   fe_word_o,
  output profiler_pkg::stall_word_u   flush_word_o
);
  import profiler_pkg::*;

  stall_word_u fetch_word;
  stall_word_u flush_word;
  stall_word_u fe_word_q;

  // A valid instruction in the queue means no fetch bubble
  always_comb begin
    fetch_word = '0;
    if (!fetch_i.iq_valid) begin
      fetch_word.flags.iq_full = ~fetch_i.iq_ready;
      fetch_word.flags.ic_miss = fetch_i.ic_miss;
      fetch_word.flags.bp_haz  = fetch_i.bp_bubble;
    end
  end

  // Fence only counts when no other flush source is active
  always_comb begin
    flush_word = '0;
    flush_word.flags.br_miss   = flush_i.branch_mispredict;
    flush_word.flags.exception = flush_i.exception;
    flush_word.flags.fence     = flush_i.flush_unissued
                               & ~(flush_i.branch_mispredict | flush_i.exception);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fe_word_q <= '0;
    end else begin
      fe_word_q.bits <= fetch_word.bits | flush_word.bits;
    end
  end

  assign fe_word_o    = fe_word_q;
  assign flush_word_o = flush_word;

endmodule

// File: source/issue_stall_stage.sv
module issue_stall_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  profiler_pkg::issue_status_s issue_i,
  input  profiler_pkg::stall_word_u   fe_word_i,
  input  profiler_pkg::stall_word_u   flush_word_i,
  output profiler_pkg::stall_word_u   is_word_o
);
  import profiler_pkg::*;

  logic        is_stall;
  stall_word_u issue_word;
  stall_word_u merged_word;
  stall_word_u is_word_q;

  // Instruction waiting at issue but not accepted
  assign is_stall = issue_i.is_valid & ~issue_i.is_ack;

  always_comb begin
    issue_word = '0;
    if (is_stall) begin
      issue_word.flags.sb_full = issue_i.sb_full;
      issue_word.flags.raw_haz = issue_i.ro_stall;
      issue_word.flags.br_haz  = issue_i.unresolved_branch;
      issue_word.flags.fu_busy = issue_i.fu_busy;
    end
  end

  // Inherited fetch reasons plus the flush seen this cycle
  always_comb begin
    merged_word.bits = fe_word_i.bits | flush_word_i.bits | issue_word.bits;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      is_word_q <= '0;
    end else begin
      is_word_q <= merged_word;
    end
  end

  assign is_word_o = is_word_q;

endmodule

// File: source/commit_stall_attrib.sv
module commit_stall_attrib (
  input  profiler_pkg::commit_status_s commit_i,
  input  profiler_pkg::stall_word_u    is_word_i,
  output logic                         stall_valid_o,
  output profiler_pkg::stall_code_e    stall_code_o,
  output logic [1:0]                   retire_o
);
  import profiler_pkg::*;

  stall_word_u cmt_word;
  stall_code_e code;

  always_comb begin
    cmt_word = is_word_i;
    cmt_word.flags.cmt_haz = commit_i.cmt_valid & ~commit_i.cmt_ack;
    // Nothing upstream explains the stall
    cmt_word.flags.unknown = ~(|cmt_word.bits[NUM_REASONS-1:1]);
  end

  // Walk from the top so the lowest set flag is the last to assign
  always_comb begin
    code = unknown;
    for (int i = NUM_REASONS - 1; i >= 0; i--) begin
      if (cmt_word.bits[i]) begin
        code = stall_code_e'(REASON_W'(i));
      end
    end
  end

  assign stall_valid_o = ~commit_i.cmt_ack;
  assign stall_code_o  = code;

  // 0 to 2 instructions per cycle
  assign retire_o = {1'b0, commit_i.cmt_ack} + {1'b0, commit_i.cmt_ack1};

endmodule

// File: source/stall_counter_bank.sv
module stall_counter_bank (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      stall_valid_i,
  input  profiler_pkg::stall_code_e stall_code_i,
  input  logic [1:0]                retire_i,
  input  profiler_pkg::apb_req_s    apb_req_i,
  output profiler_pkg::apb_rsp_s    apb_rsp_o
);
  import profiler_pkg::*;

  logic [COUNT_W-1:0] reason_cnt_q [NUM_REASONS];
  logic [COUNT_W-1:0] retire_cnt_q;
  logic               enable_q;

  logic               access;
  logic [ADDR_W-3:0]  word;
  logic [ADDR_W-3:0]  cnt_off;
  logic               in_range;
  logic               ctrl_wr;
  logic               clear;

  // Word decode of the byte address
  assign access   = apb_req_i.psel & apb_req_i.penable;
  assign word     = apb_req_i.paddr[ADDR_W-1:2];
  assign cnt_off  = word - CNT_BASE_ADDR[ADDR_W-1:2];
  assign in_range = (word <= RETIRE_ADDR[ADDR_W-1:2]);
  assign ctrl_wr  = access & apb_req_i.pwrite & (word == CTRL_ADDR[ADDR_W-1:2]);

  // Clear bit is a pulse, never stored
  assign clear = ctrl_wr & apb_req_i.pwdata[1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
    end else if (ctrl_wr) begin
      enable_q <= apb_req_i.pwdata[0];
    end
  end

  // Clear wins over counting in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || clear) begin
      for (int i = 0; i < NUM_REASONS; i++) begin
        reason_cnt_q[i] <= '0;
      end
      retire_cnt_q <= '0;
    end else if (enable_q) begin
      if (stall_valid_i) begin
        reason_cnt_q[stall_code_i] <= reason_cnt_q[stall_code_i] + 1'b1;
      end
      retire_cnt_q <= retire_cnt_q + COUNT_W'(retire_i);
    end
  end

  // No wait states
  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = 1'b1;
    if (access) begin
      apb_rsp_o.pslverr = ~in_range;
      if (!apb_req_i.pwrite && in_range) begin
        if (word == CTRL_ADDR[ADDR_W-1:2]) begin
          apb_rsp_o.prdata = {{(COUNT_W-1){1'b0}}, enable_q};
        end else if (word == RETIRE_ADDR[ADDR_W-1:2]) begin
          apb_rsp_o.prdata = retire_cnt_q;
        end else begin
          apb_rsp_o.prdata = reason_cnt_q[cnt_off[REASON_W-1:0]];
        end
      end
    end
  end

endmodule

// File: source/stall_profiler_top.sv
module stall_profiler_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  profiler_pkg::fetch_status_s  fetch_i,
  input  profiler_pkg::issue_status_s  issue_i,
  input  profiler_pkg::flush_status_s  flush_i,
  input  profiler_pkg::commit_status_s commit_i,
  input  profiler_pkg::apb_req_s       apb_req_i,
  output profiler_pkg::apb_rsp_s       apb_rsp_o
);
  import profiler_pkg::*;

  stall_word_u fe_word;
  stall_word_u flush_word;
  stall_word_u is_word;
  logic        stall_valid;
  stall_code_e stall_code;
  logic [1:0]  retire;

  frontend_stall_stage u_frontend_stall_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_i      (fetch_i),
    .flush_i      (flush_i),
    .fe_word_o    (fe_word),
    .flush_word_o (flush_word)
  );

  issue_stall_stage u_issue_stall_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .issue_i      (issue_i),
    .fe_word_i    (fe_word),
    .flush_word_i (flush_word),
    .is_word_o    (is_word)
  );

  commit_stall_attrib u_commit_stall_attrib (
    .commit_i      (commit_i),
    .is_word_i     (is_word),
    .stall_valid_o (stall_valid),
    .stall_code_o  (stall_code),
    .retire_o      (retire)
  );

  stall_counter_bank u_stall_counter_bank (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .stall_valid_i (stall_valid),
    .stall_code_i  (stall_code),
    .retire_i      (retire),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o)
  );

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Held for 16 rising edges, released off the edge
  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

// File: verification/tb_stall_profiler.sv
module tb_stall_profiler;
  timeunit 1ns;
  timeprecision 100ps;
  import profiler_pkg::*;

  logic           clk;
  logic           reset;
  fetch_status_s  fetch;
  issue_status_s  issue;
  flush_status_s  flush;
  commit_status_s commit;
  apb_req_s       apb_req;
  apb_rsp_s       apb_rsp;

  // Stimulus table, one entry per test
  string          row_name[$];
  fetch_status_s  row_fetch[$];
  issue_status_s  row_issue[$];
  flush_status_s  row_flush[$];
  commit_status_s row_commit[$];
  logic [1:0]     row_ctrl[$];
  stall_code_e    row_code[$];
  int             row_cycles[$];

  // Index NUM_REASONS holds the retire counter
  logic [COUNT_W-1:0] exp_cnt[NUM_REASONS+1];
  logic [COUNT_W-1:0] got_cnt[NUM_REASONS+1];
  int                 value_errors;
  int                 response_errors;
  int                 cycle_count;
  int                 limit_cycles;

  tb_clock_gen u_tb_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  stall_profiler_top u_stall_profiler_top (
    .clk_i     (clk),
    .reset_i   (reset),
    .fetch_i   (fetch),
    .issue_i   (issue),
    .flush_i   (flush),
    .commit_i  (commit),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (limit_cycles > 0 && cycle_count >= limit_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic add_row(input string name, input fetch_status_s f, input issue_status_s i,
                         input flush_status_s fl, input commit_status_s c,
                         input logic [1:0] ctrl, input stall_code_e code);
    row_name.push_back(name);
    row_fetch.push_back(f);
    row_issue.push_back(i);
    row_flush.push_back(fl);
    row_commit.push_back(c);
    row_ctrl.push_back(ctrl);
    row_code.push_back(code);
  endtask

  // Queue accepting, nothing flushed, port 0 retiring
  task automatic drive_idle();
    fetch  = 4'b1001;
    issue  = '0;
    flush  = '0;
    commit = 3'b010;
  endtask

  // Reasons visible at commit in cycle k of a held row
  function automatic logic [NUM_REASONS-1:0] known_flags(input int r, input int k);
    logic [NUM_REASONS-1:0] v;
    v = '0;
    v[cmt_haz] = row_commit[r].cmt_valid & ~row_commit[r].cmt_ack;
    if (k >= 2) begin
      if (row_issue[r].is_valid && !row_issue[r].is_ack) begin
        v[sb_full] = row_issue[r].sb_full;
        v[raw_haz] = row_issue[r].ro_stall;
        v[br_haz]  = row_issue[r].unresolved_branch;
        v[fu_busy] = row_issue[r].fu_busy;
      end
      v[br_miss]   = row_flush[r].branch_mispredict;
      v[exception] = row_flush[r].exception;
      v[fence]     = row_flush[r].flush_unissued & ~row_flush[r].branch_mispredict
                   & ~row_flush[r].exception;
    end
    // Fetch tags pass two registers
    if (k >= 3 && !row_fetch[r].iq_valid) begin
      v[iq_full] = ~row_fetch[r].iq_ready;
      v[ic_miss] = row_fetch[r].ic_miss;
      v[bp_haz]  = row_fetch[r].bp_bubble;
    end
    return v;
  endfunction

  function automatic stall_code_e lowest_code(input logic [NUM_REASONS-1:0] v);
    stall_code_e c;
    logic        found;
    c     = unknown;
    found = 1'b0;
    for (int i = 1; i < NUM_REASONS; i++) begin
      if (v[i] && !found) begin
        c     = stall_code_e'(REASON_W'(i));
        found = 1'b1;
      end
    end
    return c;
  endfunction

  task automatic predict_row(input int r);
    int n;
    int acks;
    n    = row_cycles[r];
    acks = int'(row_commit[r].cmt_ack) + int'(row_commit[r].cmt_ack1);
    if (row_ctrl[r][1]) begin
      foreach (exp_cnt[i]) exp_cnt[i] = '0;
    end
    if (row_ctrl[r][0]) begin
      for (int k = 1; k <= n; k++) begin
        if (!row_commit[r].cmt_ack) begin
          exp_cnt[lowest_code(known_flags(r, k))] += 1;
        end
      end
      // 4 idle cycles plus the disabling write each retire one
      exp_cnt[NUM_REASONS] += COUNT_W'(n * acks + 6);
    end
  endtask

  // Reason with the most cycles, lowest code on a tie
  function automatic stall_code_e dominant_code();
    int best;
    best = 0;
    for (int i = 1; i < NUM_REASONS; i++) begin
      if (got_cnt[i] > got_cnt[best]) best = i;
    end
    return stall_code_e'(REASON_W'(best));
  endfunction

  task automatic apb_access(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [COUNT_W-1:0] wdata, input logic exp_err,
                            output logic [COUNT_W-1:0] rdata);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1 apb_req.penable = 1'b1;
    #2;
    rdata = apb_rsp.prdata;
    if (apb_rsp.pready !== 1'b1) begin
      $display("APB access to address 0x%02h did not complete, pready was low", addr);
      response_errors++;
    end
    if (apb_rsp.pslverr !== exp_err) begin
      $display("APB access to address 0x%02h gave slave error %b where %b was expected",
               addr, apb_rsp.pslverr, exp_err);
      response_errors++;
    end
    @(posedge clk);
    #1 apb_req = '0;
  endtask

  task automatic read_counters();
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i <= NUM_REASONS; i++) begin
      addr = (i < NUM_REASONS) ? CNT_BASE_ADDR + ADDR_W'(4 * i) : RETIRE_ADDR;
      apb_access(1'b0, addr, '0, 1'b0, got_cnt[i]);
    end
  endtask

  task automatic check_count(input string name, input logic [COUNT_W-1:0] exp,
                             input logic [COUNT_W-1:0] act);
    if (act !== exp) begin
      $display("error %s: expected %0d, actual %0d", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_code(input string name, input stall_code_e exp, input stall_code_e act);
    if (act !== exp) begin
      $display("error %s: expected %s, actual %s", name, exp.name(), act.name());
      value_errors++;
    end
  endtask

  task automatic compare_counters(input string name);
    stall_code_e c;
    for (int i = 0; i < NUM_REASONS; i++) begin
      c = stall_code_e'(REASON_W'(i));
      check_count($sformatf("%s %s", name, c.name()), exp_cnt[i], got_cnt[i]);
    end
    check_count($sformatf("%s retire", name), exp_cnt[NUM_REASONS], got_cnt[NUM_REASONS]);
  endtask

  initial begin
    logic [31:0]        rng;
    logic [COUNT_W-1:0] rdata;
    int                 total;
    value_errors    = 0;
    response_errors = 0;
    cycle_count     = 0;
    limit_cycles    = 0;
    apb_req         = '0;
    drive_idle();

    // fetch {iq_ready,ic_miss,bp_bubble,iq_valid}, commit {valid,ack,ack1}, ctrl {clear,enable}
    add_row("iq_full",       4'b0000, 6'b000000, 3'b000, 3'b000, 2'b11, iq_full);
    add_row("iq_full_valid", 4'b0001, 6'b000000, 3'b000, 3'b000, 2'b11, unknown);
    add_row("ic_miss",       4'b1100, 6'b000000, 3'b000, 3'b000, 2'b11, ic_miss);
    add_row("bp_bubble",     4'b1010, 6'b000000, 3'b000, 3'b000, 2'b11, bp_haz);
    add_row("sb_full",       4'b1001, 6'b101000, 3'b000, 3'b000, 2'b11, sb_full);
    add_row("ic_miss_raw",   4'b1100, 6'b100010, 3'b000, 3'b000, 2'b11, raw_haz);
    add_row("issue_acked",   4'b1001, 6'b110010, 3'b000, 3'b000, 2'b11, unknown);
    add_row("br_haz_fu",     4'b1001, 6'b100101, 3'b000, 3'b000, 2'b11, fu_busy);
    add_row("cmt_haz",       4'b0000, 6'b101000, 3'b000, 3'b100, 2'b11, cmt_haz);
    add_row("fence",         4'b1001, 6'b000000, 3'b001, 3'b000, 2'b11, fence);
    add_row("fence_br_miss", 4'b1001, 6'b000000, 3'b101, 3'b000, 2'b11, br_miss);
    add_row("exception",     4'b1001, 6'b000000, 3'b011, 3'b000, 2'b11, exception);
    add_row("disabled",      4'b0000, 6'b000000, 3'b000, 3'b000, 2'b10, unknown);
    add_row("retire_dual",   4'b1001, 6'b000000, 3'b000, 3'b011, 2'b11, unknown);
    add_row("accumulate",    4'b0000, 6'b000000, 3'b000, 3'b000, 2'b01, iq_full);

    rng   = 32'h5884_888a;
    total = 0;
    foreach (row_name[r]) begin
      rng = xorshift32(rng);
      row_cycles.push_back(8 + int'(rng[3:0]));
      total += row_cycles[r];
    end
    limit_cycles = total + 60 * row_name.size();
    foreach (exp_cnt[i]) exp_cnt[i] = '0;

    wait (reset === 1'b0);
    @(posedge clk);
    #1;

    if (apb_rsp.pslverr !== 1'b0) begin
      $display("slave error is high after reset with no access in progress");
      response_errors++;
    end
    apb_access(1'b0, CTRL_ADDR, '0, 1'b0, rdata);
    check_count("reset ctrl", '0, rdata);
    read_counters();
    compare_counters("reset");

    foreach (row_name[r]) begin
      apb_access(1'b1, CTRL_ADDR, {30'b0, row_ctrl[r]}, 1'b0, rdata);
      fetch  = row_fetch[r];
      issue  = row_issue[r];
      flush  = row_flush[r];
      commit = row_commit[r];
      repeat (row_cycles[r]) @(posedge clk);
      #1 drive_idle();
      repeat (4) @(posedge clk);
      // Stop counting before the readback
      #1 apb_access(1'b1, CTRL_ADDR, '0, 1'b0, rdata);
      predict_row(r);
      read_counters();
      compare_counters(row_name[r]);
      check_code(row_name[r], row_code[r], dominant_code());
    end

    // Words past the retire counter
    apb_access(1'b1, 8'h38, 32'hffff_ffff, 1'b1, rdata);
    apb_access(1'b1, 8'hfc, 32'hffff_ffff, 1'b1, rdata);
    apb_access(1'b0, 8'h38, '0, 1'b1, rdata);
    apb_access(1'b0, CTRL_ADDR, '0, 1'b0, rdata);
    check_count("out_of_range ctrl", '0, rdata);
    read_counters();
    compare_counters("out_of_range");

    apb_access(1'b1, CTRL_ADDR, 32'd1, 1'b0, rdata);
    apb_access(1'b0, CTRL_ADDR, '0, 1'b0, rdata);
    check_count("enable ctrl", 32'd1, rdata);
    apb_access(1'b1, CTRL_ADDR, 32'd2, 1'b0, rdata);
    foreach (exp_cnt[i]) exp_cnt[i] = '0;
    apb_access(1'b0, CTRL_ADDR, '0, 1'b0, rdata);
    check_count("clear ctrl", '0, rdata);
    read_counters();
    compare_counters("clear");

    $display("value errors: %0d, response errors: %0d", value_errors, response_errors);
    if (value_errors == 0 && response_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
source/profiler_pkg.sv
source/frontend_stall_stage.sv
source/issue_stall_stage.sv
source/commit_stall_attrib.sv
source/stall_counter_bank.sv
source/stall_profiler_top.sv
verification/tb_clock_gen.sv
verification/tb_stall_profiler.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f compile.f --top-module tb_stall_profiler \
  -Mdir obj_dir -o sim_tb

result="$(./obj_dir/sim_tb)"
echo "$result"

if grep -qx "SIMULATION PASSED" <<< "$result"; then
  exit 0
fi
exit 1
